// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = packet_queue_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
source/queue_mem_pkg.sv
source/queue_ctrl_pkg.sv
source/page_allocator.sv
source/queue_ptr_table.sv
source/enqueue_writer.sv
source/dequeue_reader.sv
source/packet_word_ram.sv
source/packet_queue_top.sv
verif/packet_queue_assertions.sv
verif/packet_queue_tb.sv

// File: source/dequeue_reader.sv
/* Dequeue request reader */

`timescale 1ns/100ps

module dequeue_reader
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input  logic        packet_in,
    input  logic        arst_n,
    input  logic        deq_valid,
    output logic        deq_ready,
    input  queue_id_t   deq_queue,
    output logic        deq_req,
    output queue_id_t   deq_req_queue,
    input  logic        deq_gnt,
    input  mem_addr_t   deq_addr,
    input  logic        deq_empty,
    output logic        rd_en,
    output mem_addr_t   rd_addr,
    input  word_t       rd_data,
    input  ram_code_t   rd_code,
    output logic        out_valid,
    output word_t       out_data,
    output keep_t       out_keep,
    output logic        out_last,
    output byte_count_t out_bytes,
    output queue_id_t   out_queue
);

    logic [1:0] vld_pipe;
    queue_id_t  q_pipe [2];
    keep_code_t rd_keep_code;

    function automatic keep_t decode_keep(input keep_code_t code);
        keep_t keep;
        keep = '1;
        if (code != '0) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                keep[i] = (i < code);
            end
        end
        return keep;
    endfunction

    ////////////////////////////////////////////////////////////
    // Request path

    assign deq_req       = deq_valid;
    assign deq_req_queue = deq_queue;
    assign deq_ready     = deq_gnt;

    // Empty queue requests are taken but never read
    assign rd_en   = deq_gnt && !deq_empty;
    assign rd_addr = deq_addr;

    assign rd_keep_code = rd_code[$bits(keep_code_t)-1:0];

    ////////////////////////////////////////////////////////////
    // Pipeline aligned with the two RAM read stages

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe  <= '0;
            out_valid <= 1'b0;
        end else begin
            vld_pipe  <= {vld_pipe[0], rd_en};
            out_valid <= vld_pipe[1];
        end
    end

    // Output word and side band, registered
    always_ff @(posedge packet_in) begin
        q_pipe[0] <= deq_queue;
        q_pipe[1] <= q_pipe[0];
        out_queue <= q_pipe[1];
        out_data  <= rd_data;
        out_keep  <= decode_keep(rd_keep_code);
        out_last  <= rd_code[$bits(ram_code_t)-1];
        out_bytes <= (rd_keep_code == '0) ? byte_count_t'(WORD_BYTES)
                                          : byte_count_t'(rd_keep_code);
    end

endmodule

// File: source/enqueue_writer.sv
/* Enqueue stream writer */

`timescale 1ns/100ps

module enqueue_writer
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input  logic      packet_in,
    input  logic      arst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  word_t     in_data,
    input  keep_t     in_keep,
    input  logic      in_last,
    input  queue_id_t in_queue,
    output logic      enq_req,
    output queue_id_t enq_queue,
    input  logic      enq_gnt,
    input  mem_addr_t enq_addr,
    output logic      wr_en,
    output mem_addr_t wr_addr,
    output word_t     wr_data,
    output ram_code_t wr_code
);

    pkt_state_t pkt_state;
    queue_id_t  pkt_queue;
    logic       accept;

    // Position of the lowest clear byte above byte 0, zero when full
    function automatic keep_code_t encode_keep(input keep_t keep);
        keep_code_t code;
        code = '0;
        for (int i = WORD_BYTES - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                code = keep_code_t'(i);
            end
        end
        return code;
    endfunction

    ////////////////////////////////////////////////////////////
    // Table request

    // Queue comes from the stream only on the first word
    assign enq_queue = (pkt_state == pkt_idle) ? in_queue : pkt_queue;
    assign enq_req   = in_valid;
    assign in_ready  = enq_gnt;
    assign accept    = in_valid && enq_gnt;

    ////////////////////////////////////////////////////////////
    // Word memory write

    assign wr_en   = accept;
    assign wr_addr = enq_addr;
    assign wr_data = in_data;
    assign wr_code = {in_last, encode_keep(in_keep)};

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            pkt_state <= pkt_idle;
            pkt_queue <= '0;
        end else if (accept) begin
            if (pkt_state == pkt_idle) begin
                pkt_queue <= in_queue;
            end
            pkt_state <= in_last ? pkt_idle : pkt_body;
        end
    end

endmodule

// File: source/packet_queue_top.sv
/* Paged packet queue top */

`timescale 1ns/100ps

module packet_queue_top
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  word_t                 in_data,
    input  keep_t                 in_keep,
    input  logic                  in_last,
    input  queue_id_t             in_queue,
    input  logic                  deq_valid,
    output logic                  deq_ready,
    input  queue_id_t             deq_queue,
    output logic                  out_valid,
    output word_t                 out_data,
    output keep_t                 out_keep,
    output logic                  out_last,
    output byte_count_t           out_bytes,
    output queue_id_t             out_queue,
    output logic [NUM_QUEUES-1:0] queue_nonempty,
    output page_count_t           free_pages
);

    ////////////////////////////////////////////////////////////
    // Interconnect

    logic      enq_req, enq_gnt;
    queue_id_t enq_queue;
    mem_addr_t enq_addr;
    logic      deq_req, deq_gnt, deq_empty;
    queue_id_t deq_req_queue;
    mem_addr_t deq_addr;
    logic      alloc_take, alloc_avail, free_valid;
    page_ptr_t alloc_page, free_page;
    logic      wr_en, rd_en;
    mem_addr_t wr_addr, rd_addr;
    word_t     wr_data, rd_data;
    ram_code_t wr_code, rd_code;

    enqueue_writer u_writer (
        .packet_in, .arst_n,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last, .in_queue,
        .enq_req, .enq_queue, .enq_gnt, .enq_addr,
        .wr_en, .wr_addr, .wr_data, .wr_code
    );

    dequeue_reader u_reader (
        .packet_in, .arst_n,
        .deq_valid, .deq_ready, .deq_queue,
        .deq_req, .deq_req_queue, .deq_gnt, .deq_addr, .deq_empty,
        .rd_en, .rd_addr, .rd_data, .rd_code,
        .out_valid, .out_data, .out_keep, .out_last, .out_bytes, .out_queue
    );

    queue_ptr_table u_table (
        .packet_in, .arst_n,
        .enq_req, .enq_queue, .enq_gnt, .enq_addr,
        .deq_req, .deq_req_queue, .deq_gnt, .deq_addr, .deq_empty,
        .alloc_avail, .alloc_take, .alloc_page,
        .free_valid, .free_page, .queue_nonempty
    );

    page_allocator u_alloc (
        .packet_in, .arst_n,
        .alloc_take, .alloc_avail, .alloc_page,
        .free_valid, .free_page, .free_pages
    );

    packet_word_ram u_ram (
        .packet_in,
        .wr_en, .wr_addr, .wr_data, .wr_code,
        .rd_en, .rd_addr, .rd_data, .rd_code
    );

endmodule

// File: source/packet_word_ram.sv
/* Packet word memory */

`timescale 1ns/100ps

module packet_word_ram
    import queue_mem_pkg::*;
(
    input  logic      packet_in,
    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  word_t     wr_data,
    input  ram_code_t wr_code,
    input  logic      rd_en,
    input  mem_addr_t rd_addr,
    output word_t     rd_data,
    output ram_code_t rd_code
);

    word_t     data_mem [MEM_DEPTH];
    ram_code_t code_mem [MEM_DEPTH];

    // First read stage, the array output register
    word_t     data_q;
    ram_code_t code_q;

    always_ff @(posedge packet_in) begin
        if (wr_en) begin
            data_mem[wr_addr] <= wr_data;
            code_mem[wr_addr] <= wr_code;
        end
    end

    always_ff @(posedge packet_in) begin
        if (rd_en) begin
            data_q <= data_mem[rd_addr];
            code_q <= code_mem[rd_addr];
        end
        // Second stage
        rd_data <= data_q;
        rd_code <= code_q;
    end

endmodule

// File: source/page_allocator.sv
/* Free page bitmap allocator */

`timescale 1ns/100ps

module page_allocator
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input  logic        packet_in,
    input  logic        arst_n,
    input  logic        alloc_take,
    output logic        alloc_avail,
    output page_ptr_t   alloc_page,
    input  logic        free_valid,
    input  page_ptr_t   free_page,
    output page_count_t free_pages
);

    // One bit per page, set while the page is free
    logic [NUM_PAGES-1:0] free_map;
    logic [NUM_PAGES-1:0] free_map_next;

    assign alloc_avail = |free_map;

    // Lowest free page wins
    always_comb begin
        alloc_page = '0;
        for (int i = NUM_PAGES - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_page = page_ptr_t'(i);
            end
        end
    end

    always_comb begin
        free_map_next = free_map;
        if (alloc_take) begin
            free_map_next[alloc_page] = 1'b0;
        end
        if (free_valid) begin
            free_map_next[free_page] = 1'b1;
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            free_map   <= '1;
            free_pages <= page_count_t'(NUM_PAGES);
        end else begin
            free_map   <= free_map_next;
            // Take and free can land in the same cycle
            free_pages <= free_pages + page_count_t'(free_valid) - page_count_t'(alloc_take);
        end
    end

endmodule

// File: source/queue_ctrl_pkg.sv
/* Queue control types */

package queue_ctrl_pkg;

    import queue_mem_pkg::*;

    localparam int NUM_QUEUES = 4;

    typedef logic [$clog2(NUM_QUEUES)-1:0] queue_id_t;

    // Words held by one queue, up to the whole memory
    typedef logic [$clog2(MEM_DEPTH+1)-1:0] word_count_t;

    // Free pages, 0 to NUM_PAGES
    typedef logic [$clog2(NUM_PAGES+1)-1:0] page_count_t;

    // Last winner of the table arbiter
    typedef enum logic {
        owner_enq,
        owner_deq
    } arb_owner_t;

    // Start of packet tracking in the writer
    typedef enum logic {
        pkt_idle,
        pkt_body
    } pkt_state_t;

endpackage

// File: source/queue_mem_pkg.sv
/* Queue memory geometry */

package queue_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry

    localparam int WORD_BYTES     = 8;
    localparam int WORDS_PER_PAGE = 4;
    localparam int NUM_PAGES      = 16;
    localparam int MEM_DEPTH      = WORDS_PER_PAGE * NUM_PAGES;

    ////////////////////////////////////////////////////////////
    // Word and keep types

    typedef logic [WORD_BYTES*8-1:0] word_t;
    typedef logic [WORD_BYTES-1:0]   keep_t;

    // Zero means a full word, otherwise the number of valid low bytes
    typedef logic [$clog2(WORD_BYTES)-1:0] keep_code_t;

    // Valid bytes of a word, 1 to 8
    typedef logic [$clog2(WORD_BYTES):0] byte_count_t;

    // Keep code with the last flag in the top bit
    typedef logic [$clog2(WORD_BYTES):0] ram_code_t;

    ////////////////////////////////////////////////////////////
    // Addressing

    typedef logic [$clog2(NUM_PAGES)-1:0]      page_ptr_t;
    typedef logic [$clog2(WORDS_PER_PAGE)-1:0] word_offset_t;

    // Page number above word offset
    typedef logic [$clog2(MEM_DEPTH)-1:0] mem_addr_t;

endpackage

// File: source/queue_ptr_table.sv
/* Queue pointer table and arbiter */

`timescale 1ns/100ps

module queue_ptr_table
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input  logic                  packet_in,
    input  logic                  arst_n,
    input  logic                  enq_req,
    input  queue_id_t             enq_queue,
    output logic                  enq_gnt,
    output mem_addr_t             enq_addr,
    input  logic                  deq_req,
    input  queue_id_t             deq_req_queue,
    output logic                  deq_gnt,
    output mem_addr_t             deq_addr,
    output logic                  deq_empty,
    input  logic                  alloc_avail,
    output logic                  alloc_take,
    input  page_ptr_t             alloc_page,
    output logic                  free_valid,
    output page_ptr_t             free_page,
    output logic [NUM_QUEUES-1:0] queue_nonempty
);

    localparam word_offset_t LAST_OFFSET = word_offset_t'(WORDS_PER_PAGE - 1);

    page_ptr_t    head_page [NUM_QUEUES];
    word_offset_t head_off  [NUM_QUEUES];
    page_ptr_t    tail_page [NUM_QUEUES];
    word_offset_t tail_off  [NUM_QUEUES];
    word_count_t  count     [NUM_QUEUES];
    page_ptr_t    link      [NUM_PAGES];
    arb_owner_t   last_winner;

    logic         enq_need_page;
    logic         enq_ok;
    page_ptr_t    enq_page;
    word_offset_t enq_off;
    logic         deq_last_off;

    ////////////////////////////////////////////////////////////
    // Address generation

    // New page for an empty queue or after a full tail page
    assign enq_need_page = (count[enq_queue] == '0) || (tail_off[enq_queue] == LAST_OFFSET);
    assign enq_ok        = enq_req && (!enq_need_page || alloc_avail);
    assign enq_page      = enq_need_page ? alloc_page : tail_page[enq_queue];
    assign enq_off       = enq_need_page ? '0 : word_offset_t'(tail_off[enq_queue] + 1'b1);
    assign enq_addr      = {enq_page, enq_off};

    assign deq_empty    = (count[deq_req_queue] == '0);
    assign deq_last_off = (head_off[deq_req_queue] == LAST_OFFSET);
    assign deq_addr     = {head_page[deq_req_queue], head_off[deq_req_queue]};

    ////////////////////////////////////////////////////////////
    // Round-robin arbiter

    // Writer wins unless the reader also asks and the writer won last
    assign enq_gnt = enq_ok && (!deq_req || last_winner == owner_deq);
    assign deq_gnt = deq_req && !enq_gnt;

    assign alloc_take = enq_gnt && enq_need_page;
    assign free_page  = head_page[deq_req_queue];
    assign free_valid = deq_gnt && !deq_empty
                        && (deq_last_off || count[deq_req_queue] == word_count_t'(1));

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            queue_nonempty[q] = (count[q] != '0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointer state

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            last_winner <= owner_deq;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                head_page[q] <= '0;
                head_off[q]  <= '0;
                tail_page[q] <= '0;
                tail_off[q]  <= '0;
                count[q]     <= '0;
            end
        end else begin
            if (enq_gnt) begin
                last_winner          <= owner_enq;
                count[enq_queue]     <= count[enq_queue] + 1'b1;
                tail_page[enq_queue] <= enq_page;
                tail_off[enq_queue]  <= enq_off;
                // First word of an empty queue also sets head
                if (count[enq_queue] == '0) begin
                    head_page[enq_queue] <= enq_page;
                    head_off[enq_queue]  <= '0;
                end
            end
            if (deq_gnt) begin
                last_winner <= owner_deq;
                if (!deq_empty) begin
                    count[deq_req_queue] <= count[deq_req_queue] - 1'b1;
                    if (deq_last_off) begin
                        head_page[deq_req_queue] <= link[head_page[deq_req_queue]];
                        head_off[deq_req_queue]  <= '0;
                    end else begin
                        head_off[deq_req_queue] <= head_off[deq_req_queue] + 1'b1;
                    end
                end
            end
        end
    end

    // Chain the new page behind the old tail page
    always_ff @(posedge packet_in) begin
        if (alloc_take && count[enq_queue] != '0) begin
            link[tail_page[enq_queue]] <= alloc_page;
        end
    end

endmodule

// File: verif/packet_queue_assertions.sv
/* Packet queue assertions */

`timescale 1ns/100ps

module packet_queue_assertions
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
(
    input logic        packet_in,
    input logic        arst_n,
    input logic        enq_gnt,
    input logic        deq_gnt,
    input logic        deq_valid,
    input logic        deq_ready,
    input logic        deq_empty,
    input logic        out_valid,
    input logic        alloc_take,
    input logic        alloc_avail,
    input page_count_t free_pages
);

    // Accepted request that reads a word
    logic deq_read;
    assign deq_read = deq_valid && deq_ready && !deq_empty;

    ////////////////////////////////////////////////////////////
    // Arbiter and allocator

    grant_one: assert property (@(posedge packet_in) disable iff (!arst_n)
        !(enq_gnt && deq_gnt))
        else $error("Writer and reader granted in the same cycle");

    take_with_free: assert property (@(posedge packet_in) disable iff (!arst_n)
        alloc_take |-> alloc_avail)
        else $error("Page taken while no page is free");

    pages_bounded: assert property (@(posedge packet_in) disable iff (!arst_n)
        free_pages <= page_count_t'(NUM_PAGES))
        else $error("Free page count above the page total");

    ////////////////////////////////////////////////////////////
    // Read latency

    read_to_out: assert property (@(posedge packet_in) disable iff (!arst_n)
        deq_read |-> ##3 out_valid)
        else $error("Output word missing three cycles after a read");

    out_from_read: assert property (@(posedge packet_in) disable iff (!arst_n)
        out_valid |-> $past(deq_read, 3))
        else $error("Output word without a read three cycles before");

endmodule

bind packet_queue_top packet_queue_assertions u_assertions (
    .packet_in   (packet_in),
    .arst_n      (arst_n),
    .enq_gnt     (enq_gnt),
    .deq_gnt     (deq_gnt),
    .deq_valid   (deq_valid),
    .deq_ready   (deq_ready),
    .deq_empty   (deq_empty),
    .out_valid   (out_valid),
    .alloc_take  (alloc_take),
    .alloc_avail (alloc_avail),
    .free_pages  (free_pages)
);

// File: verif/packet_queue_tb.sv
/* Packet queue testbench */

`timescale 1ns/100ps

module packet_queue_tb
    import queue_mem_pkg::*, queue_ctrl_pkg::*;
();

    localparam int STIM_CYCLES = 2000;
    // Drain of at most 64 stored words fits well inside the extra cycles
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;
    localparam int SEED = 69720;

    typedef struct packed {
        logic  last;
        keep_t keep;
        word_t data;
    } entry_t;

    logic                  packet_in;
    logic                  arst_n;
    logic                  in_valid;
    logic                  in_ready;
    word_t                 in_data;
    keep_t                 in_keep;
    logic                  in_last;
    queue_id_t             in_queue;
    logic                  deq_valid;
    logic                  deq_ready;
    queue_id_t             deq_queue;
    logic                  out_valid;
    word_t                 out_data;
    keep_t                 out_keep;
    logic                  out_last;
    byte_count_t           out_bytes;
    queue_id_t             out_queue;
    logic [NUM_QUEUES-1:0] queue_nonempty;
    page_count_t           free_pages;

    // Reference queues and the words expected on the output
    entry_t    model_q [NUM_QUEUES][$];
    int        head_off_m [NUM_QUEUES];
    logic      exp_valid [4];
    entry_t    exp_entry [4];
    queue_id_t exp_queue [4];

    logic      in_acc;
    logic      deq_acc;
    int        words_left;
    queue_id_t pkt_queue;
    int        stim_cycle;
    int        cycle_count = 0;
    int        checks;
    int        errors;

    packet_queue_top dut_i (
        .packet_in, .arst_n,
        .in_valid, .in_ready, .in_data, .in_keep, .in_last, .in_queue,
        .deq_valid, .deq_ready, .deq_queue,
        .out_valid, .out_data, .out_keep, .out_last, .out_bytes, .out_queue,
        .queue_nonempty, .free_pages
    );

    initial begin
        packet_in = 1'b0;
        forever #10 packet_in = ~packet_in;
    end

    ////////////////////////////////////////////////////////////
    // Reference model helpers

    // Next word opens a page when the queue is empty or its tail page is full
    function automatic logic needs_page(input queue_id_t q);
        int n;
        n = model_q[q].size();
        return (n == 0) || (((head_off_m[q] + n - 1) % WORDS_PER_PAGE) == WORDS_PER_PAGE - 1);
    endfunction

    function automatic int model_free_pages();
        int used;
        used = 0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (model_q[q].size() != 0) begin
                used += (head_off_m[q] + model_q[q].size() + WORDS_PER_PAGE - 1) / WORDS_PER_PAGE;
            end
        end
        return NUM_PAGES - used;
    endfunction

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (model_q[q].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    function automatic int keep_bytes(input keep_t keep);
        int n;
        n = 0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (keep[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus

    task automatic drive_enqueue(input logic stim_on);
        int nbytes;
        if (!in_valid || in_acc) begin
            if (stim_on && ($urandom % 4) != 0) begin
                if (words_left == 0) begin
                    words_left = 1 + int'($urandom % 6);
                    pkt_queue  = queue_id_t'($urandom % NUM_QUEUES);
                    in_queue <= pkt_queue;
                end else begin
                    // Body words carry a queue number the writer must ignore
                    in_queue <= queue_id_t'($urandom % NUM_QUEUES);
                end
                in_valid <= 1'b1;
                in_data  <= {$urandom, $urandom};
                in_last  <= (words_left == 1);
                if (words_left == 1) begin
                    nbytes = 1 + int'($urandom % WORD_BYTES);
                    in_keep <= keep_t'((9'd1 << nbytes) - 9'd1);
                end else begin
                    in_keep <= '1;
                end
                words_left--;
            end else begin
                in_valid <= 1'b0;
            end
        end
    endtask

    task automatic drive_dequeue(input logic stim_on);
        int        deq_pct;
        logic      found;
        queue_id_t pick;
        // Slow and fast read phases so memory fills up and drains
        deq_pct = ((stim_cycle / 250) % 2 == 0) ? 15 : 60;
        found   = 1'b0;
        pick    = '0;
        if (!deq_valid || deq_acc) begin
            if (stim_on) begin
                deq_valid <= (($urandom % 100) < deq_pct);
                deq_queue <= queue_id_t'($urandom % NUM_QUEUES);
            end else begin
                // Drain the lowest queue still holding words
                for (int q = NUM_QUEUES - 1; q >= 0; q--) begin
                    if (model_q[q].size() != 0) begin
                        found = 1'b1;
                        pick  = queue_id_t'(q);
                    end
                end
                deq_valid <= found;
                deq_queue <= pick;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Mid-cycle checks and model update

    task automatic check_cycle();
        logic [NUM_QUEUES-1:0] exp_nonempty;
        entry_t                ent;
        for (int i = 3; i > 0; i--) begin
            exp_valid[i] = exp_valid[i-1];
            exp_entry[i] = exp_entry[i-1];
            exp_queue[i] = exp_queue[i-1];
        end
        exp_valid[0] = 1'b0;

        compare_value("out_valid", 64'(out_valid), 64'(exp_valid[3]));
        if (exp_valid[3]) begin
            compare_value("out_data", out_data, exp_entry[3].data);
            compare_value("out_keep", 64'(out_keep), 64'(exp_entry[3].keep));
            compare_value("out_last", 64'(out_last), 64'(exp_entry[3].last));
            compare_value("out_queue", 64'(out_queue), 64'(exp_queue[3]));
            compare_value("out_bytes", 64'(out_bytes), 64'(keep_bytes(exp_entry[3].keep)));
        end

        for (int q = 0; q < NUM_QUEUES; q++) begin
            exp_nonempty[q] = (model_q[q].size() != 0);
        end
        compare_value("queue_nonempty", 64'(queue_nonempty), 64'(exp_nonempty));
        compare_value("free_pages", 64'(free_pages), 64'(model_free_pages()));
        // Writer must stall when its word needs a page and none is left
        if (in_valid && model_free_pages() == 0 && needs_page(pkt_queue)) begin
            compare_value("in_ready", 64'(in_ready), 64'd0);
        end

        // The word on the bus always belongs to the current stimulus packet
        in_acc  = in_valid && in_ready;
        deq_acc = deq_valid && deq_ready;
        if (in_acc) begin
            if (model_q[pkt_queue].size() == 0) begin
                head_off_m[pkt_queue] = 0;
            end
            model_q[pkt_queue].push_back(entry_t'({in_last, in_keep, in_data}));
        end
        // Empty queue requests are taken with no word behind them
        if (deq_acc && model_q[deq_queue].size() != 0) begin
            ent          = model_q[deq_queue].pop_front();
            exp_valid[0] = 1'b1;
            exp_entry[0] = ent;
            exp_queue[0] = deq_queue;
            if (model_q[deq_queue].size() == 0) begin
                head_off_m[deq_queue] = 0;
            end else begin
                head_off_m[deq_queue] = (head_off_m[deq_queue] + 1) % WORDS_PER_PAGE;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        logic done;
        void'($urandom(SEED));
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        in_queue   = '0;
        deq_valid  = 1'b0;
        deq_queue  = '0;
        in_acc     = 1'b0;
        deq_acc    = 1'b0;
        words_left = 0;
        pkt_queue  = '0;
        stim_cycle = 0;
        checks     = 0;
        errors     = 0;
        done       = 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_valid[i] = 1'b0;
        end
        for (int q = 0; q < NUM_QUEUES; q++) begin
            head_off_m[q] = 0;
        end

        // Reset held over four rising edges
        repeat (3) @(posedge packet_in);
        @(negedge packet_in);
        compare_value("in_ready", 64'(in_ready), 64'd0);
        compare_value("deq_ready", 64'(deq_ready), 64'd0);
        compare_value("out_valid", 64'(out_valid), 64'd0);
        compare_value("free_pages", 64'(free_pages), 64'(NUM_PAGES));
        compare_value("queue_nonempty", 64'(queue_nonempty), 64'd0);
        @(posedge packet_in);
        arst_n <= 1'b1;

        while (!done) begin
            @(posedge packet_in);
            drive_enqueue(stim_cycle < STIM_CYCLES);
            drive_dequeue(stim_cycle < STIM_CYCLES);
            @(negedge packet_in);
            check_cycle();
            stim_cycle++;
            done = (errors != 0)
                   || (stim_cycle >= STIM_CYCLES && !in_valid && !deq_valid && model_empty()
                       && !exp_valid[0] && !exp_valid[1] && !exp_valid[2]);
        end

        if (errors == 0) begin
            @(posedge packet_in);
            @(negedge packet_in);
            compare_value("free_pages", 64'(free_pages), 64'(NUM_PAGES));
            compare_value("queue_nonempty", 64'(queue_nonempty), 64'd0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Timeout

    always @(posedge packet_in) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
